// ==== hdl/ila_pkg.sv ====
package ila_pkg;

	////////////////////////////////////////
	// Host command set

	// One opcode byte, then argument bytes; multi-byte replies big endian
	typedef enum logic [7:0] {
		CMD_NOP                = 8'h00, // No operation
		CMD_SET_MATCH_ALL      = 8'h01, // 1 arg, bit 0 selects AND
		CMD_SET_TRIG_MODE      = 8'h03, // Channel byte, then mode byte
		CMD_SET_COMPARE_TARGET = 8'h04, // Channel byte, then target byte
		CMD_ARM                = 8'h05, // Arm the trigger
		CMD_STOP               = 8'h06, // Disarm, abort capture
		CMD_FORCE              = 8'h07, // Trigger now, if armed
		CMD_GET_STATUS         = 8'h08, // 1 byte reply
		CMD_GET_CHANNEL_COUNT  = 8'h0a, // 1 byte reply
		CMD_GET_DATA           = 8'h0d, // DEPTH lines of CHANNELS bytes
		CMD_GET_DEPTH          = 8'h0e  // 2 byte reply
	} ila_cmd_t;

	////////////////////////////////////////
	// Comparators

	// Code 3 is unassigned and acts as never
	typedef enum logic [1:0] {
		COMPARE_NEVER     = 2'd0,
		COMPARE_EQUAL     = 2'd1,
		COMPARE_NOT_EQUAL = 2'd2
	} ila_compare_t;

	localparam int SAMPLE_BITS = 8; // Bits per probe channel

	////////////////////////////////////////
	// Status byte

	localparam int STATUS_ARMED     = 0;
	localparam int STATUS_CAPTURING = 1;
	localparam int STATUS_DONE      = 2; // Remaining bits read as zero

	// Serial framing
	// Start bit, 8 data bits, stop bit
	localparam int UART_FRAME_BITS = 10;

endpackage

// ==== hdl/ila_ctrl_if.sv ====
interface ila_ctrl_if #(
	parameter int CHANNELS = 2,
	parameter int DEPTH    = 16
);
	import ila_pkg::*;

	localparam int ADDR_BITS = $clog2(DEPTH);

	// Trigger setup, held by the decoder
	logic                                 match_all;      // 1 = AND, 0 = OR
	ila_compare_t [CHANNELS-1:0]          compare_mode;
	logic [CHANNELS-1:0][SAMPLE_BITS-1:0] compare_target;

	// Single-cycle control strobes
	logic arm;
	logic stop;
	logic force_trig;

	// Buffer readback, data one cycle after rd_en
	logic                                 rd_en;
	logic [ADDR_BITS-1:0]                 rd_addr;
	logic [CHANNELS-1:0][SAMPLE_BITS-1:0] rd_data;

	logic [7:0] status; // Armed, capturing, done flags

	modport cmd (output match_all, compare_mode, compare_target, arm, stop, force_trig,
		rd_en, rd_addr, input status, rd_data);
	modport capture (input match_all, compare_mode, compare_target, arm, stop, force_trig,
		rd_en, rd_addr, output status, rd_data);

endinterface

// ==== hdl/uart_rx.sv ====
module uart_rx (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] clkdiv, // Clock cycles per bit
	input  logic        rxd,
	output logic        rx_valid,
	output logic [7:0]  rx_data
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t   state;
	logic        rxd_meta;  // Line synchronizer
	logic        rxd_s;
	logic [15:0] bit_cnt;   // Cycles into current bit
	logic [2:0]  bit_idx;
	logic [7:0]  shift;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= RX_IDLE;
			rxd_meta <= 1'b1; // Idle line is high
			rxd_s    <= 1'b1;
			rx_valid <= 1'b0;
			bit_cnt  <= '0;
			bit_idx  <= '0;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					if (!rxd_s)
						state <= RX_START; // Falling edge, possible start bit
				end
				RX_START: begin
					if (bit_cnt == {1'b0, clkdiv[15:1]}) begin // Middle of start bit
						bit_cnt <= '0;
						bit_idx <= '0;
						state   <= rxd_s ? RX_IDLE : RX_DATA; // Glitch goes back to idle
					end else
						bit_cnt <= bit_cnt + 16'd1;
				end
				RX_DATA: begin
					if (bit_cnt == clkdiv - 16'd1) begin
						bit_cnt <= '0;
						shift   <= {rxd_s, shift[7:1]}; // LSB first
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else
						bit_cnt <= bit_cnt + 16'd1;
				end
				default: begin // RX_STOP
					if (bit_cnt == clkdiv - 16'd1) begin
						state <= RX_IDLE;
						if (rxd_s) begin // Framing error drops the byte
							rx_valid <= 1'b1;
							rx_data  <= shift;
						end
					end else
						bit_cnt <= bit_cnt + 16'd1;
				end
			endcase
		end
	end

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] clkdiv,  // Clock cycles per bit
	input  logic        tx_en,   // Load strobe, only honored when idle
	input  logic [7:0]  tx_data,
	output logic        txd,
	output logic        tx_done  // End of stop bit
);

	logic        busy;
	logic [15:0] bit_cnt;
	logic [3:0]  bit_idx;  // 0 is start bit, 9 is stop bit
	logic [8:0]  shift;    // Data bits, then stop bit

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			txd     <= 1'b1;
			tx_done <= 1'b0;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				if (tx_en) begin
					busy    <= 1'b1;
					txd     <= 1'b0; // Start bit
					shift   <= {1'b1, tx_data};
					bit_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (bit_cnt == clkdiv - 16'd1) begin
				bit_cnt <= '0;
				if (bit_idx == 4'd9) begin // Stop bit finished
					busy    <= 1'b0;
					tx_done <= 1'b1;
				end else begin
					txd     <= shift[0];
					shift   <= {1'b1, shift[8:1]}; // Back-fill with idle level
					bit_idx <= bit_idx + 4'd1;
				end
			end else
				bit_cnt <= bit_cnt + 16'd1;
		end
	end

endmodule

// ==== hdl/ila_capture.sv ====
module ila_capture #(
	parameter int CHANNELS = 2,
	parameter int DEPTH    = 16
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic [CHANNELS-1:0][ila_pkg::SAMPLE_BITS-1:0] probe_in,
	output logic                                          trig_out,
	ila_ctrl_if.capture                                   ctrl
);
	import ila_pkg::*;

	localparam int ADDR_BITS = $clog2(DEPTH);

	////////////////////////////////////////
	// Comparators

	logic [CHANNELS-1:0] hit;    // Per-channel compare result
	logic [CHANNELS-1:0] active; // Channel takes part in trigger
	logic                match;

	always_comb begin
		for (int i = 0; i < CHANNELS; i++) begin
			hit[i]    = 1'b0;
			active[i] = 1'b0;
			case (ctrl.compare_mode[i])
				COMPARE_EQUAL: begin
					active[i] = 1'b1;
					hit[i]    = (probe_in[i] == ctrl.compare_target[i]);
				end
				COMPARE_NOT_EQUAL: begin
					active[i] = 1'b1;
					hit[i]    = (probe_in[i] != ctrl.compare_target[i]);
				end
				default: ; // Never, plus unassigned code
			endcase
		end
	end

	// AND ignores inactive channels but needs at least one active
	assign match = ctrl.match_all ? (|active && &(hit | ~active)) : |hit;

	////////////////////////////////////////
	// Capture sequencer

	logic                 armed;
	logic                 capturing;
	logic                 done;
	logic [ADDR_BITS-1:0] wr_ptr;  // Next write slot during capture
	logic [ADDR_BITS-1:0] wr_addr;

	// Trigger sample lands in slot 0 in the same cycle
	assign trig_out = armed && !capturing && (match || ctrl.force_trig);
	assign wr_addr  = capturing ? wr_ptr : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			armed     <= 1'b0;
			capturing <= 1'b0;
			done      <= 1'b0;
			wr_ptr    <= '0;
		end else begin
			if (capturing) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (wr_ptr == ADDR_BITS'(DEPTH - 1)) begin // Buffer full
					capturing <= 1'b0;
					armed     <= 1'b0;
					done      <= 1'b1;
				end
			end else if (trig_out) begin
				capturing <= 1'b1;
				wr_ptr    <= ADDR_BITS'(1);
			end else if (ctrl.arm) begin // Ignored while capturing
				armed <= 1'b1;
				done  <= 1'b0;
			end
			if (ctrl.stop) begin // Abort wins over everything
				armed     <= 1'b0;
				capturing <= 1'b0;
			end
		end
	end

	always_comb begin
		ctrl.status                   = '0;
		ctrl.status[STATUS_ARMED]     = armed;
		ctrl.status[STATUS_CAPTURING] = capturing;
		ctrl.status[STATUS_DONE]      = done;
	end

	////////////////////////////////////////
	// Sample buffer

	logic [CHANNELS-1:0][SAMPLE_BITS-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (trig_out || capturing)
			mem[wr_addr] <= probe_in;
		if (ctrl.rd_en)
			ctrl.rd_data <= mem[ctrl.rd_addr]; // Synchronous read port
	end

endmodule

// ==== hdl/ila_cmd.sv ====
module ila_cmd #(
	parameter int CHANNELS = 2,
	parameter int DEPTH    = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	output logic       tx_en,
	output logic [7:0] tx_data,
	input  logic       tx_done,
	ila_ctrl_if.cmd    ctrl
);
	import ila_pkg::*;

	localparam int          ADDR_BITS  = $clog2(DEPTH);
	localparam logic [15:0] DEPTH_WORD = 16'(DEPTH); // Depth as sent to host

	typedef enum logic [2:0] {
		ST_IDLE,      // Waiting for opcode
		ST_CHANNEL,   // Channel index argument
		ST_ARG,       // Mode, target or match-all byte
		ST_TX_HOLD,   // Last reply byte in flight
		ST_DEPTH,     // Depth high byte in flight
		ST_DATA_WAIT, // Buffer read pending
		ST_DATA_SEND  // Sending bytes of one line
	} state_t;

	state_t                          state;
	ila_cmd_t                        cur_cmd;
	logic [7:0]                      cur_channel;
	logic [7:0]                      byte_idx;   // Byte of line now on the wire
	logic [CHANNELS*SAMPLE_BITS-1:0] line;       // Rest of line, next byte at bottom

	always_ff @(posedge clk) begin
		if (rst) begin
			state             <= ST_IDLE;
			cur_cmd           <= CMD_NOP;
			cur_channel       <= '0;
			byte_idx          <= '0;
			tx_en             <= 1'b0;
			ctrl.arm          <= 1'b0;
			ctrl.stop         <= 1'b0;
			ctrl.force_trig   <= 1'b0;
			ctrl.rd_en        <= 1'b0;
			ctrl.rd_addr      <= '0;
			ctrl.match_all    <= 1'b0; // OR combine
			for (int i = 0; i < CHANNELS; i++)
				ctrl.compare_mode[i] <= COMPARE_NEVER;
		end else begin
			// Strobes last one cycle
			tx_en           <= 1'b0;
			ctrl.arm        <= 1'b0;
			ctrl.stop       <= 1'b0;
			ctrl.force_trig <= 1'b0;
			ctrl.rd_en      <= 1'b0;

			case (state)
				////////////////////////////////////////
				// Opcode dispatch
				ST_IDLE: begin
					if (rx_valid) begin
						cur_cmd <= ila_cmd_t'(rx_data);
						case (ila_cmd_t'(rx_data))
							CMD_SET_MATCH_ALL:      state <= ST_ARG;
							CMD_SET_TRIG_MODE:      state <= ST_CHANNEL;
							CMD_SET_COMPARE_TARGET: state <= ST_CHANNEL;
							CMD_ARM:                ctrl.arm        <= 1'b1;
							CMD_STOP:               ctrl.stop       <= 1'b1;
							CMD_FORCE:              ctrl.force_trig <= 1'b1;
							CMD_GET_STATUS: begin
								tx_en   <= 1'b1;
								tx_data <= ctrl.status;
								state   <= ST_TX_HOLD;
							end
							CMD_GET_CHANNEL_COUNT: begin
								tx_en   <= 1'b1;
								tx_data <= 8'(CHANNELS);
								state   <= ST_TX_HOLD;
							end
							CMD_GET_DEPTH: begin
								tx_en   <= 1'b1;
								tx_data <= DEPTH_WORD[15:8]; // Big endian
								state   <= ST_DEPTH;
							end
							CMD_GET_DATA: begin
								ctrl.rd_en   <= 1'b1;
								ctrl.rd_addr <= '0;
								byte_idx     <= '0;
								state        <= ST_DATA_WAIT;
							end
							default: ; // NOP and unknown codes
						endcase
					end
				end

				////////////////////////////////////////
				// Configuration arguments
				ST_CHANNEL: begin
					if (rx_valid) begin
						cur_channel <= rx_data;
						state       <= ST_ARG;
					end
				end
				ST_ARG: begin
					if (rx_valid) begin
						state <= ST_IDLE;
						if (cur_cmd == CMD_SET_MATCH_ALL)
							ctrl.match_all <= rx_data[0];
						// Out of range channel matches nothing here
						for (int i = 0; i < CHANNELS; i++) begin
							if (cur_channel == 8'(i)) begin
								if (cur_cmd == CMD_SET_TRIG_MODE)
									ctrl.compare_mode[i] <= ila_compare_t'(rx_data[1:0]);
								else if (cur_cmd == CMD_SET_COMPARE_TARGET)
									ctrl.compare_target[i] <= rx_data;
							end
						end
					end
				end

				////////////////////////////////////////
				// Replies
				ST_TX_HOLD: begin
					if (tx_done)
						state <= ST_IDLE; // Command complete
				end
				ST_DEPTH: begin
					if (tx_done) begin
						tx_en   <= 1'b1;
						tx_data <= DEPTH_WORD[7:0];
						state   <= ST_TX_HOLD;
					end
				end
				ST_DATA_WAIT: begin
					if (!ctrl.rd_en) begin // Read data valid now
						tx_en   <= 1'b1;
						tx_data <= ctrl.rd_data[0];
						line    <= ctrl.rd_data >> SAMPLE_BITS;
						state   <= ST_DATA_SEND;
					end
				end
				default: begin // ST_DATA_SEND
					if (tx_done) begin
						if (byte_idx == 8'(CHANNELS - 1)) begin
							byte_idx <= '0;
							if (ctrl.rd_addr == ADDR_BITS'(DEPTH - 1))
								state <= ST_IDLE; // Last line sent
							else begin
								ctrl.rd_en   <= 1'b1;
								ctrl.rd_addr <= ctrl.rd_addr + 1'b1;
								state        <= ST_DATA_WAIT;
							end
						end else begin
							tx_en    <= 1'b1;
							tx_data  <= line[7:0];
							line     <= line >> SAMPLE_BITS;
							byte_idx <= byte_idx + 8'd1;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== hdl/ila_uart_top.sv ====
module ila_uart_top #(
	parameter int CHANNELS = 2,  // 1 to 255
	parameter int DEPTH    = 16  // Power of two
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic [CHANNELS-1:0][ila_pkg::SAMPLE_BITS-1:0] probe_in,
	input  logic [15:0]                                   clkdiv,  // Cycles per UART bit
	input  logic                                          uart_rxd,
	output logic                                          uart_txd,
	output logic                                          trig_out
);

	////////////////////////////////////////
	// Serial link

	logic       rx_valid;
	logic [7:0] rx_data;
	logic       tx_en;
	logic [7:0] tx_data;
	logic       tx_done;

	uart_rx u_rx (
		.clk      (clk),
		.rst      (rst),
		.clkdiv   (clkdiv),
		.rxd      (uart_rxd),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	uart_tx u_tx (
		.clk     (clk),
		.rst     (rst),
		.clkdiv  (clkdiv),
		.tx_en   (tx_en),
		.tx_data (tx_data),
		.txd     (uart_txd),
		.tx_done (tx_done)
	);

	////////////////////////////////////////
	// Decoder and capture engine

	ila_ctrl_if #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) ctrl_bus ();

	ila_cmd #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) u_cmd (
		.clk      (clk),
		.rst      (rst),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.tx_en    (tx_en),
		.tx_data  (tx_data),
		.tx_done  (tx_done),
		.ctrl     (ctrl_bus.cmd)
	);

	ila_capture #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) u_capture (
		.clk      (clk),
		.rst      (rst),
		.probe_in (probe_in),
		.trig_out (trig_out),
		.ctrl     (ctrl_bus.capture)
	);

endmodule

// ==== tests/tb_uart_host.svh ====
`ifndef TB_UART_HOST_SVH
`define TB_UART_HOST_SVH

////////////////////////////////////////
// Host side of the serial link

// One 8N1 frame onto uart_rxd, LSB first
task automatic send_byte(input logic [7:0] data);
	logic [UART_FRAME_BITS-1:0] frame;
	frame = {1'b1, data, 1'b0}; // Stop, data, start
	for (int i = 0; i < UART_FRAME_BITS; i++) begin
		@(posedge clk);
		uart_rxd <= frame[i];
		repeat (BIT_CYCLES - 1) @(posedge clk); // Hold for one bit time
	end
endtask

// One reply frame from uart_txd
// Sampled on falling clock edges, away from the DUT's register updates
task automatic recv_byte(output logic [7:0] data);
	@(negedge clk);
	while (uart_txd !== 1'b0)
		@(negedge clk); // Idle line, wait for start edge
	repeat (BIT_CYCLES / 2) @(negedge clk); // Middle of start bit
	assert (uart_txd == 1'b0) else
		report_failure("Start bit on uart_txd ended before mid-bit");
	for (int i = 0; i < 8; i++) begin
		repeat (BIT_CYCLES) @(negedge clk);
		data[i] = uart_txd; // LSB first
	end
	repeat (BIT_CYCLES) @(negedge clk); // Middle of stop bit
	assert (uart_txd == 1'b1) else
		report_failure("Reply byte on uart_txd has a low stop bit");
endtask

// Opcode out, one reply byte back and checked
task automatic ask_expect(input logic [7:0] cmd, input string name,
		input logic [7:0] exp);
	logic [7:0] got;
	send_byte(cmd);
	recv_byte(got);
	expect_byte(name, got, exp);
endtask

// Opcode, channel index, argument
task automatic config_channel(input logic [7:0] cmd, input logic [7:0] ch,
		input logic [7:0] arg);
	send_byte(cmd);
	send_byte(ch);
	send_byte(arg);
endtask

`endif

// ==== tests/tb_ila_uart.sv ====
module tb_ila_uart;
	import ila_pkg::*;

	localparam int CHANNELS        = 2;
	localparam int DEPTH           = 16;
	localparam int BIT_CYCLES      = 8;   // clkdiv
	localparam int SEED            = 54463;
	localparam int TRIG_WAIT_LIMIT = 256 + 4 * DEPTH; // One counter wrap plus slack
	localparam int TIMEOUT_CYCLES  = (40 * UART_FRAME_BITS * BIT_CYCLES + 2000) * 4;

	// Expected status bytes
	localparam logic [7:0] STAT_IDLE  = 8'h00;
	localparam logic [7:0] STAT_ARMED = 8'(1 << STATUS_ARMED);
	localparam logic [7:0] STAT_DONE  = 8'(1 << STATUS_DONE);

	logic                       clk;
	logic                       rst;
	logic [CHANNELS-1:0][7:0]   probe_in;
	logic [15:0]                clkdiv;
	logic                       uart_rxd;
	logic                       uart_txd;
	logic                       trig_out;

	logic [7:0] probe_cnt;          // Channel 0 source
	logic [7:0] cap_ch0 [DEPTH];    // Readback, per channel
	logic [7:0] cap_ch1 [DEPTH];
	logic [7:0] target_t;
	logic [7:0] target_v;
	logic [7:0] trig_sample;        // Counter value seen during trig_out
	int         cycle_count = 0;

	ila_uart_top #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) uut (
		.clk      (clk),
		.rst      (rst),
		.probe_in (probe_in),
		.clkdiv   (clkdiv),
		.uart_rxd (uart_rxd),
		.uart_txd (uart_txd),
		.trig_out (trig_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Counter on channel 0, inverse on channel 1
	always @(posedge clk)
		probe_cnt <= probe_cnt + 8'd1;
	assign probe_in = {~probe_cnt, probe_cnt};

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			report_failure("Timeout, the run did not finish in the cycle budget");
	end

	// One cycle pulse only
	assert property (@(posedge clk) disable iff (rst) !(trig_out && $past(trig_out))) else
		report_failure("trig_out stayed high for two consecutive cycles");

	////////////////////////////////////////
	// Checking helpers

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic expect_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		assert (got === exp) else
			report_failure($sformatf("FAILED %s expected %h got %h", name, exp, got));
	endtask

	`include "tb_uart_host.svh"

	// Returns on the negedge inside the pulse
	task automatic wait_trigger();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!trig_out) begin
			waited++;
			assert (waited < TRIG_WAIT_LIMIT) else
				report_failure("trig_out did not pulse after the trigger condition");
			@(negedge clk);
		end
		trig_sample = probe_cnt; // Sample compared in the trigger cycle
	endtask

	// GET_DATA, channel 0 byte first in each line
	task automatic read_buffer();
		logic [7:0] b;
		send_byte(CMD_GET_DATA);
		for (int k = 0; k < DEPTH; k++) begin
			recv_byte(b);
			cap_ch0[k] = b;
			recv_byte(b);
			cap_ch1[k] = b;
		end
	endtask

	// Consecutive counter values from first on
	task automatic check_samples(input logic [7:0] first);
		logic [7:0] exp;
		for (int k = 0; k < DEPTH; k++) begin
			exp = first + 8'(k);
			expect_byte($sformatf("cap_ch0[%0d]", k), cap_ch0[k], exp);
			expect_byte($sformatf("cap_ch1[%0d]", k), cap_ch1[k], ~exp);
		end
	endtask

	////////////////////////////////////////
	// Scenarios

	initial begin
		void'($urandom(SEED));
		rst       = 1'b1;
		uart_rxd  = 1'b1; // Idle line
		clkdiv    = 16'(BIT_CYCLES);
		probe_cnt = 8'h00;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Reset values and fixed replies
		ask_expect(CMD_GET_STATUS, "status", STAT_IDLE);
		ask_expect(CMD_GET_CHANNEL_COUNT, "channel_count", 8'(CHANNELS));
		ask_expect(CMD_GET_DEPTH, "depth_hi", 8'(DEPTH / 256)); // Big endian
		recv_byte(target_t); // Low byte follows on its own
		expect_byte("depth_lo", target_t, 8'(DEPTH % 256));
		send_byte(8'h3f); // Unknown code, dropped
		send_byte(CMD_NOP);
		ask_expect(CMD_GET_STATUS, "status", STAT_IDLE);

		// Arm with all modes never, then stop
		send_byte(CMD_ARM);
		ask_expect(CMD_GET_STATUS, "status", STAT_ARMED);
		send_byte(CMD_STOP);
		ask_expect(CMD_GET_STATUS, "status", STAT_IDLE);

		// Equal trigger on channel 0
		target_t = 8'($urandom);
		config_channel(CMD_SET_TRIG_MODE, 8'd0, 8'(COMPARE_EQUAL));
		config_channel(CMD_SET_COMPARE_TARGET, 8'd0, target_t);
		send_byte(CMD_ARM);
		wait_trigger();
		ask_expect(CMD_GET_STATUS, "status", STAT_DONE);
		read_buffer();
		check_samples(target_t);

		// AND of two targets that never coincide
		// Inverse of T+1 keeps the OR match high for two cycles
		target_v = ~(target_t + 8'd1);
		config_channel(CMD_SET_TRIG_MODE, 8'd1, 8'(COMPARE_EQUAL));
		config_channel(CMD_SET_COMPARE_TARGET, 8'd1, target_v);
		send_byte(CMD_SET_MATCH_ALL);
		send_byte(8'h01);
		send_byte(CMD_ARM);
		repeat (512) begin // Two counter wraps
			@(negedge clk);
			assert (!trig_out) else
				report_failure("trig_out fired under match_all without a joint match");
		end
		ask_expect(CMD_GET_STATUS, "status", STAT_ARMED);
		send_byte(CMD_SET_MATCH_ALL);
		send_byte(8'h00); // Back to OR
		wait_trigger();
		ask_expect(CMD_GET_STATUS, "status", STAT_DONE);
		read_buffer();
		assert (cap_ch0[0] == target_t || cap_ch1[0] == target_v) else
			report_failure("Captured sample 0 matches neither channel target");
		check_samples(trig_sample);

		// Forced trigger, no comparator active
		config_channel(CMD_SET_TRIG_MODE, 8'd0, 8'(COMPARE_NEVER));
		config_channel(CMD_SET_TRIG_MODE, 8'd1, 8'(COMPARE_NEVER));
		send_byte(CMD_ARM);
		send_byte(CMD_FORCE);
		wait_trigger();
		ask_expect(CMD_GET_STATUS, "status", STAT_DONE);
		read_buffer();
		check_samples(trig_sample);

		$display("No errors");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+tests
hdl/ila_pkg.sv
hdl/ila_ctrl_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/ila_capture.sv
hdl/ila_cmd.sv
hdl/ila_uart_top.sv
tests/tb_ila_uart.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tb_ila_uart -o tb_ila_uart

./obj_dir/tb_ila_uart
